// ==== hdl/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
(
	input logic clk,
	input logic reset,
	input logic [mipsCtrlPkg::OpcodeWidth-1:0] opcode,
	input logic [mipsCtrlPkg::FunctWidth-1:0] funct,
	input logic [mipsCtrlPkg::ShamtWidth-1:0] shamt,
	input logic menor,
	output logic memWrite,
	output logic mdrWrite,
	output logic pcWrite,
	output logic pcCond,
	output logic branchOnEqual,
	output logic irWrite,
	output logic aWrite,
	output logic bWrite,
	output logic regWrite,
	output logic aluSrcA,
	output logic aluOutWrite,
	output logic epcWrite,
	output mipsCtrlPkg::pcSource_t pcSource,
	output mipsCtrlPkg::aluSrcB_t aluSrcB,
	output mipsCtrlPkg::aluOp_t aluControl,
	output mipsCtrlPkg::regDst_t regDst,
	output mipsCtrlPkg::memToReg_t memToReg,
	output mipsCtrlPkg::addrSel_t addrSel,
	output mipsCtrlPkg::ctrlState_t state
);

	mipsCtrlPkg::instrClass_t instrClass;

	instrDecoder decoder
	(
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.instrClass(instrClass)
	);

	stateSequencer sequencer
	(
		.clk(clk),
		.reset(reset),
		.instrClass(instrClass),
		.state(state)
	);

	controlWordGen wordGen
	(
		.state(state),
		.menor(menor),
		.memWrite(memWrite),
		.mdrWrite(mdrWrite),
		.pcWrite(pcWrite),
		.pcCond(pcCond),
		.branchOnEqual(branchOnEqual),
		.irWrite(irWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.aluOutWrite(aluOutWrite),
		.epcWrite(epcWrite),
		.pcSource(pcSource),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regDst(regDst),
		.memToReg(memToReg),
		.addrSel(addrSel)
	);

endmodule

// ==== hdl/controlWordGen.sv ====
`timescale 1ns/1ps

module controlWordGen
(
	input mipsCtrlPkg::ctrlState_t state,
	input logic menor,
	output logic memWrite,
	output logic mdrWrite,
	output logic pcWrite,
	output logic pcCond,
	output logic branchOnEqual,
	output logic irWrite,
	output logic aWrite,
	output logic bWrite,
	output logic regWrite,
	output logic aluSrcA,
	output logic aluOutWrite,
	output logic epcWrite,
	output mipsCtrlPkg::pcSource_t pcSource,
	output mipsCtrlPkg::aluSrcB_t aluSrcB,
	output mipsCtrlPkg::aluOp_t aluControl,
	output mipsCtrlPkg::regDst_t regDst,
	output mipsCtrlPkg::memToReg_t memToReg,
	output mipsCtrlPkg::addrSel_t addrSel
);

	always_comb
	begin
		memWrite = 1'b0;
		mdrWrite = 1'b0;
		pcWrite = 1'b0;
		pcCond = 1'b0;
		branchOnEqual = 1'b0;
		irWrite = 1'b0;
		aWrite = 1'b0;
		bWrite = 1'b0;
		regWrite = 1'b0;
		aluSrcA = 1'b1; // register A
		aluOutWrite = 1'b0;
		epcWrite = 1'b0;
		pcSource = mipsCtrlPkg::PcAluResult;
		aluSrcB = mipsCtrlPkg::SrcBRegB;
		aluControl = mipsCtrlPkg::AluAdd;
		regDst = mipsCtrlPkg::DstRt;
		memToReg = mipsCtrlPkg::WbAluOut;
		addrSel = mipsCtrlPkg::AddrAluOut;

		case (state)
			mipsCtrlPkg::MemoryRead, mipsCtrlPkg::WaitMemoryRead, mipsCtrlPkg::IRWrite:
			begin
				addrSel = mipsCtrlPkg::AddrPc;
				irWrite = 1'b1;
				aluSrcA = 1'b0;
				aluSrcB = mipsCtrlPkg::SrcBFour;
				pcWrite = (state == mipsCtrlPkg::IRWrite); // pc + 4
			end
			mipsCtrlPkg::Decode:
			begin
				aluSrcA = 1'b0;
				aluSrcB = mipsCtrlPkg::SrcBImmShifted; // branch target into aluOut
				aluOutWrite = 1'b1;
				aWrite = 1'b1;
				bWrite = 1'b1;
			end
			mipsCtrlPkg::Add:
			begin
				aluControl = mipsCtrlPkg::AluAdd;
				aluOutWrite = 1'b1;
			end
			mipsCtrlPkg::And:
			begin
				aluControl = mipsCtrlPkg::AluAnd;
				aluOutWrite = 1'b1;
			end
			mipsCtrlPkg::Sub:
			begin
				aluControl = mipsCtrlPkg::AluSub;
				aluOutWrite = 1'b1;
			end
			mipsCtrlPkg::Xor:
			begin
				aluControl = mipsCtrlPkg::AluXor;
				aluOutWrite = 1'b1;
			end
			mipsCtrlPkg::WriteRegAlu:
			begin
				regWrite = 1'b1;
				regDst = mipsCtrlPkg::DstRd;
				memToReg = mipsCtrlPkg::WbAluOut;
			end
			mipsCtrlPkg::Slt:
				aluControl = mipsCtrlPkg::AluSlt;
			mipsCtrlPkg::SltWrite:
			begin
				aluControl = mipsCtrlPkg::AluSlt; // keeps menor valid
				regWrite = 1'b1;
				regDst = mipsCtrlPkg::DstRd;
				memToReg = menor ? mipsCtrlPkg::WbOne : mipsCtrlPkg::WbZero;
			end
			mipsCtrlPkg::Beq, mipsCtrlPkg::Bne:
			begin
				pcCond = 1'b1;
				pcSource = mipsCtrlPkg::PcAluOut;
				aluControl = mipsCtrlPkg::AluSub; // zero flag decides
				branchOnEqual = (state == mipsCtrlPkg::Beq);
			end
			mipsCtrlPkg::Lw, mipsCtrlPkg::Sw, mipsCtrlPkg::Addiu:
			begin
				aluSrcB = mipsCtrlPkg::SrcBImm;
				aluOutWrite = 1'b1;
			end
			mipsCtrlPkg::SwAddr, mipsCtrlPkg::SwWait:
				memWrite = 1'b1;
			mipsCtrlPkg::LwMdr:
				mdrWrite = 1'b1;
			mipsCtrlPkg::LwWrite:
			begin
				regWrite = 1'b1;
				regDst = mipsCtrlPkg::DstRt;
				memToReg = mipsCtrlPkg::WbMdr;
			end
			mipsCtrlPkg::Lui:
			begin
				regWrite = 1'b1;
				regDst = mipsCtrlPkg::DstRt;
				memToReg = mipsCtrlPkg::WbLuiImm;
			end
			mipsCtrlPkg::J, mipsCtrlPkg::Jal:
			begin
				pcWrite = 1'b1;
				pcSource = mipsCtrlPkg::PcJumpTarget;
			end
			mipsCtrlPkg::Jr:
			begin
				pcWrite = 1'b1;
				pcSource = mipsCtrlPkg::PcRegA;
			end
			mipsCtrlPkg::JalWriteRa:
			begin
				regWrite = 1'b1;
				regDst = mipsCtrlPkg::DstRa;
				memToReg = mipsCtrlPkg::WbPc; // return address
			end
			mipsCtrlPkg::WriteRegAluImm:
			begin
				regWrite = 1'b1;
				regDst = mipsCtrlPkg::DstRt;
				memToReg = mipsCtrlPkg::WbAluOut;
			end
			mipsCtrlPkg::ExcSaveEpc:
			begin
				epcWrite = 1'b1;
				aluSrcA = 1'b0;
				aluSrcB = mipsCtrlPkg::SrcBFour;
				aluControl = mipsCtrlPkg::AluSub; // epc = pc - 4
				addrSel = mipsCtrlPkg::AddrExcVector;
			end
			mipsCtrlPkg::ExcWait:
				addrSel = mipsCtrlPkg::AddrExcVector;
			mipsCtrlPkg::ExcMdr:
			begin
				addrSel = mipsCtrlPkg::AddrExcVector;
				mdrWrite = 1'b1; // handler address from memory
			end
			mipsCtrlPkg::ExcJump:
			begin
				pcWrite = 1'b1;
				pcSource = mipsCtrlPkg::PcExcVector;
			end
			mipsCtrlPkg::Break:
			begin
				aluSrcA = 1'b0;
				aluControl = mipsCtrlPkg::AluLoadA;
				addrSel = mipsCtrlPkg::AddrPc;
			end
			default:
			begin
				aluSrcA = 1'b1; // Reset and Nop keep the default word
			end
		endcase
	end

endmodule

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder
(
	input logic [mipsCtrlPkg::OpcodeWidth-1:0] opcode,
	input logic [mipsCtrlPkg::FunctWidth-1:0] funct,
	input logic [mipsCtrlPkg::ShamtWidth-1:0] shamt,
	output mipsCtrlPkg::instrClass_t instrClass
);

	mipsCtrlPkg::instrClass_t rClass; // class of an R-type word

	always_comb
	begin
		case (mipsCtrlPkg::funct_t'(funct))
			mipsCtrlPkg::FnSll:
			begin
				if (shamt == '0)
					rClass = mipsCtrlPkg::ClsNop;
				else
					rClass = mipsCtrlPkg::ClsIllegal; // real shifts unsupported
			end
			mipsCtrlPkg::FnJr: rClass = mipsCtrlPkg::ClsJr;
			mipsCtrlPkg::FnBreak: rClass = mipsCtrlPkg::ClsBreak;
			mipsCtrlPkg::FnAdd: rClass = mipsCtrlPkg::ClsAdd;
			mipsCtrlPkg::FnSub: rClass = mipsCtrlPkg::ClsSub;
			mipsCtrlPkg::FnAnd: rClass = mipsCtrlPkg::ClsAnd;
			mipsCtrlPkg::FnXor: rClass = mipsCtrlPkg::ClsXor;
			mipsCtrlPkg::FnSlt: rClass = mipsCtrlPkg::ClsSlt;
			default: rClass = mipsCtrlPkg::ClsIllegal;
		endcase
	end

	always_comb
	begin
		case (mipsCtrlPkg::opcode_t'(opcode))
			mipsCtrlPkg::OpRType: instrClass = rClass;
			mipsCtrlPkg::OpJ: instrClass = mipsCtrlPkg::ClsJ;
			mipsCtrlPkg::OpJal: instrClass = mipsCtrlPkg::ClsJal;
			mipsCtrlPkg::OpBeq: instrClass = mipsCtrlPkg::ClsBeq;
			mipsCtrlPkg::OpBne: instrClass = mipsCtrlPkg::ClsBne;
			mipsCtrlPkg::OpAddiu: instrClass = mipsCtrlPkg::ClsAddiu;
			mipsCtrlPkg::OpLui: instrClass = mipsCtrlPkg::ClsLui;
			mipsCtrlPkg::OpLw: instrClass = mipsCtrlPkg::ClsLw;
			mipsCtrlPkg::OpSw: instrClass = mipsCtrlPkg::ClsSw;
			default: instrClass = mipsCtrlPkg::ClsIllegal; // unknown opcode traps
		endcase
	end

endmodule

// ==== hdl/mipsCtrlPkg.sv ====
package mipsCtrlPkg;

	localparam int OpcodeWidth = 6;
	localparam int FunctWidth = 6;
	localparam int ShamtWidth = 5;
	localparam int ClassWidth = 5;
	localparam int StateWidth = 6;

	// primary opcodes, standard MIPS-I values
	typedef enum logic [OpcodeWidth-1:0] {
		OpRType = 6'h00,
		OpJ = 6'h02,
		OpJal = 6'h03,
		OpBeq = 6'h04,
		OpBne = 6'h05,
		OpAddiu = 6'h09,
		OpLui = 6'h0f,
		OpLw = 6'h23,
		OpSw = 6'h2b
	} opcode_t;

	typedef enum logic [FunctWidth-1:0] {
		FnSll = 6'h00, // nop only
		FnJr = 6'h08,
		FnBreak = 6'h0d,
		FnAdd = 6'h20,
		FnSub = 6'h22,
		FnAnd = 6'h24,
		FnXor = 6'h26,
		FnSlt = 6'h2a
	} funct_t;

	typedef enum logic [ClassWidth-1:0] {
		ClsAdd, ClsAnd, ClsSub, ClsXor, ClsSlt, ClsJr, ClsBreak, ClsNop,
		ClsBeq, ClsBne, ClsLw, ClsSw, ClsLui, ClsJ, ClsJal, ClsAddiu,
		ClsIllegal
	} instrClass_t;

	typedef enum logic [StateWidth-1:0] {
		Reset, MemoryRead, WaitMemoryRead, IRWrite, Decode, // fetch ring
		Add, And, Sub, Xor, WriteRegAlu,
		Slt, SltWrite,
		Break, Nop, Beq, Bne,
		Lw, LwAddr, LwWait, LwMdr, LwWrite,
		Sw, SwAddr, SwWait,
		Lui, J, Jr, JalWriteRa, Jal,
		Addiu, WriteRegAluImm,
		ExcSaveEpc, ExcWait, ExcMdr, ExcJump // illegal instruction trap
	} ctrlState_t;

	typedef enum logic [2:0] {
		AluLoadA = 3'b000,
		AluAdd = 3'b001,
		AluSub = 3'b010,
		AluAnd = 3'b011,
		AluXor = 3'b110,
		AluSlt = 3'b111
	} aluOp_t;

	typedef enum logic [2:0] {
		PcAluResult = 3'b000,
		PcAluOut = 3'b001, // branch target from decode
		PcJumpTarget = 3'b010,
		PcRegA = 3'b011,
		PcExcVector = 3'b101
	} pcSource_t;

	typedef enum logic [1:0] {
		SrcBRegB = 2'b00,
		SrcBFour = 2'b01,
		SrcBImm = 2'b10,
		SrcBImmShifted = 2'b11
	} aluSrcB_t;

	typedef enum logic [1:0] {
		DstRt = 2'b00,
		DstRd = 2'b01,
		DstRa = 2'b10 // r31
	} regDst_t;

	typedef enum logic [2:0] {
		WbAluOut = 3'b000,
		WbMdr = 3'b001,
		WbLuiImm = 3'b010,
		WbZero = 3'b011,
		WbOne = 3'b100,
		WbPc = 3'b110
	} memToReg_t;

	typedef enum logic [1:0] {
		AddrPc = 2'b00,
		AddrAluOut = 2'b01,
		AddrExcVector = 2'b10
	} addrSel_t;

endpackage

// ==== hdl/stateSequencer.sv ====
`timescale 1ns/1ps

module stateSequencer
(
	input logic clk,
	input logic reset,
	input mipsCtrlPkg::instrClass_t instrClass,
	output mipsCtrlPkg::ctrlState_t state
);

	mipsCtrlPkg::ctrlState_t nextState;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= mipsCtrlPkg::Reset;
		else
			state <= nextState;
	end

	always_comb
	begin
		case (state)
			mipsCtrlPkg::Reset: nextState = mipsCtrlPkg::MemoryRead;
			mipsCtrlPkg::MemoryRead: nextState = mipsCtrlPkg::WaitMemoryRead;
			mipsCtrlPkg::WaitMemoryRead: nextState = mipsCtrlPkg::IRWrite;
			mipsCtrlPkg::IRWrite: nextState = mipsCtrlPkg::Decode;
			mipsCtrlPkg::Decode:
			begin
				case (instrClass) // only place the class is sampled
					mipsCtrlPkg::ClsAdd: nextState = mipsCtrlPkg::Add;
					mipsCtrlPkg::ClsAnd: nextState = mipsCtrlPkg::And;
					mipsCtrlPkg::ClsSub: nextState = mipsCtrlPkg::Sub;
					mipsCtrlPkg::ClsXor: nextState = mipsCtrlPkg::Xor;
					mipsCtrlPkg::ClsSlt: nextState = mipsCtrlPkg::Slt;
					mipsCtrlPkg::ClsJr: nextState = mipsCtrlPkg::Jr;
					mipsCtrlPkg::ClsBreak: nextState = mipsCtrlPkg::Break;
					mipsCtrlPkg::ClsNop: nextState = mipsCtrlPkg::Nop;
					mipsCtrlPkg::ClsBeq: nextState = mipsCtrlPkg::Beq;
					mipsCtrlPkg::ClsBne: nextState = mipsCtrlPkg::Bne;
					mipsCtrlPkg::ClsLw: nextState = mipsCtrlPkg::Lw;
					mipsCtrlPkg::ClsSw: nextState = mipsCtrlPkg::Sw;
					mipsCtrlPkg::ClsLui: nextState = mipsCtrlPkg::Lui;
					mipsCtrlPkg::ClsJ: nextState = mipsCtrlPkg::J;
					mipsCtrlPkg::ClsJal: nextState = mipsCtrlPkg::JalWriteRa;
					mipsCtrlPkg::ClsAddiu: nextState = mipsCtrlPkg::Addiu;
					default: nextState = mipsCtrlPkg::ExcSaveEpc;
				endcase
			end
			mipsCtrlPkg::Add, mipsCtrlPkg::And, mipsCtrlPkg::Sub, mipsCtrlPkg::Xor:
				nextState = mipsCtrlPkg::WriteRegAlu;
			mipsCtrlPkg::Slt: nextState = mipsCtrlPkg::SltWrite;
			mipsCtrlPkg::Break: nextState = mipsCtrlPkg::Break; // halt until reset
			mipsCtrlPkg::Lw: nextState = mipsCtrlPkg::LwAddr;
			mipsCtrlPkg::LwAddr: nextState = mipsCtrlPkg::LwWait;
			mipsCtrlPkg::LwWait: nextState = mipsCtrlPkg::LwMdr;
			mipsCtrlPkg::LwMdr: nextState = mipsCtrlPkg::LwWrite;
			mipsCtrlPkg::Sw: nextState = mipsCtrlPkg::SwAddr;
			mipsCtrlPkg::SwAddr: nextState = mipsCtrlPkg::SwWait;
			mipsCtrlPkg::JalWriteRa: nextState = mipsCtrlPkg::Jal;
			mipsCtrlPkg::Addiu: nextState = mipsCtrlPkg::WriteRegAluImm;
			mipsCtrlPkg::ExcSaveEpc: nextState = mipsCtrlPkg::ExcWait;
			mipsCtrlPkg::ExcWait: nextState = mipsCtrlPkg::ExcMdr;
			mipsCtrlPkg::ExcMdr: nextState = mipsCtrlPkg::ExcJump;
			mipsCtrlPkg::WriteRegAlu, mipsCtrlPkg::SltWrite, mipsCtrlPkg::Nop,
			mipsCtrlPkg::Beq, mipsCtrlPkg::Bne, mipsCtrlPkg::LwWrite,
			mipsCtrlPkg::SwWait, mipsCtrlPkg::Lui, mipsCtrlPkg::J,
			mipsCtrlPkg::Jr, mipsCtrlPkg::Jal, mipsCtrlPkg::WriteRegAluImm,
			mipsCtrlPkg::ExcJump:
				nextState = mipsCtrlPkg::MemoryRead; // last step, back to fetch
			default: nextState = mipsCtrlPkg::Reset; // unused encodings
		endcase
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# builds the controlUnit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module controlUnitTb -o controlUnitSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/controlUnitSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
	exit 1
fi
exit 0

// ==== tb.f ====
hdl/mipsCtrlPkg.sv
hdl/instrDecoder.sv
hdl/stateSequencer.sv
hdl/controlWordGen.sv
hdl/controlUnit.sv
testbench/controlUnit_sva.sv
testbench/controlUnitTb.sv

// ==== testbench/controlUnitTb.sv ====
`timescale 1ns/1ps

module controlUnitTb;

	localparam int ClkPeriod = 10;
	localparam int ResetCycles = 16;
	// budget per test, waiting for IRWrite included
	localparam int TestCycles = 12 + 4 * 10 + 2 * 10 + 11 + 13 + 2 * 9 + 2 * 9 + 10 + 9 + 10
		+ 2 * 12 + 26;
	localparam int Margin = 100;

	logic clk;
	logic reset;
	logic menor;
	logic [mipsCtrlPkg::OpcodeWidth-1:0] opcode;
	logic [mipsCtrlPkg::FunctWidth-1:0] funct;
	logic [mipsCtrlPkg::ShamtWidth-1:0] shamt;
	logic memWrite;
	logic mdrWrite;
	logic pcWrite;
	logic pcCond;
	logic branchOnEqual;
	logic irWrite;
	logic aWrite;
	logic bWrite;
	logic regWrite;
	logic aluSrcA;
	logic aluOutWrite;
	logic epcWrite;
	mipsCtrlPkg::pcSource_t pcSource;
	mipsCtrlPkg::aluSrcB_t aluSrcB;
	mipsCtrlPkg::aluOp_t aluControl;
	mipsCtrlPkg::regDst_t regDst;
	mipsCtrlPkg::memToReg_t memToReg;
	mipsCtrlPkg::addrSel_t addrSel;
	mipsCtrlPkg::ctrlState_t state;

	int errors;
	int cycles;
	int startCycle;
	int nRegWrite; // pulses seen since the last IRWrite
	int nMemWrite;
	int nMdrWrite;
	int nPcWrite;
	int nPcCond;
	int nEpcWrite;

	controlUnit DUT
	(
		.clk(clk),
		.reset(reset),
		.opcode(opcode),
		.funct(funct),
		.shamt(shamt),
		.menor(menor),
		.memWrite(memWrite),
		.mdrWrite(mdrWrite),
		.pcWrite(pcWrite),
		.pcCond(pcCond),
		.branchOnEqual(branchOnEqual),
		.irWrite(irWrite),
		.aWrite(aWrite),
		.bWrite(bWrite),
		.regWrite(regWrite),
		.aluSrcA(aluSrcA),
		.aluOutWrite(aluOutWrite),
		.epcWrite(epcWrite),
		.pcSource(pcSource),
		.aluSrcB(aluSrcB),
		.aluControl(aluControl),
		.regDst(regDst),
		.memToReg(memToReg),
		.addrSel(addrSel),
		.state(state)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	initial
	begin
		#((ResetCycles + TestCycles + Margin) * ClkPeriod);
		$display("Timeout: the tests did not finish within their cycle budget");
		$display("Some tests failed");
		$finish;
	end

	task automatic noteFailure(input string msg);
		errors++;
		$display("At %0t: %s", $time, msg);
	endtask

	task automatic checkState(input mipsCtrlPkg::ctrlState_t exp);
		if (state !== exp)
		begin
			errors++;
			$display("ERROR at %0t: state expected %s got %s", $time, exp.name(), state.name());
		end
	endtask

	task automatic checkBit(input string name, input logic exp, input logic actual);
		if (actual !== exp)
		begin
			errors++;
			$display("ERROR at %0t: %s expected %b got %b", $time, name, exp, actual);
		end
	endtask

	task automatic checkAluOp(input mipsCtrlPkg::aluOp_t exp);
		if (aluControl !== exp)
		begin
			errors++;
			$display("ERROR at %0t: aluControl expected %s got %s", $time, exp.name(),
				aluControl.name());
		end
	endtask

	task automatic checkPcSource(input mipsCtrlPkg::pcSource_t exp);
		if (pcSource !== exp)
		begin
			errors++;
			$display("ERROR at %0t: pcSource expected %s got %s", $time, exp.name(),
				pcSource.name());
		end
	endtask

	task automatic checkWb(input mipsCtrlPkg::regDst_t expDst, input mipsCtrlPkg::memToReg_t expWb);
		if (regDst !== expDst)
		begin
			errors++;
			$display("ERROR at %0t: regDst expected %s got %s", $time, expDst.name(),
				regDst.name());
		end
		if (memToReg !== expWb)
		begin
			errors++;
			$display("ERROR at %0t: memToReg expected %s got %s", $time, expWb.name(),
				memToReg.name());
		end
	endtask

	task automatic checkSrcB(input mipsCtrlPkg::aluSrcB_t exp);
		if (aluSrcB !== exp)
		begin
			errors++;
			$display("ERROR at %0t: aluSrcB expected %s got %s", $time, exp.name(),
				aluSrcB.name());
		end
	endtask

	task automatic checkAddrSel(input mipsCtrlPkg::addrSel_t exp);
		if (addrSel !== exp)
		begin
			errors++;
			$display("ERROR at %0t: addrSel expected %s got %s", $time, exp.name(),
				addrSel.name());
		end
	endtask

	task automatic checkCount(input string name, input int exp, input int actual);
		if (actual != exp)
		begin
			errors++;
			$display("ERROR at %0t: %s pulse count expected %0d got %0d", $time, name, exp, actual);
		end
	endtask

	// halted word is all zero
	task automatic checkHaltWord();
		checkBit("memWrite", 1'b0, memWrite);
		checkBit("mdrWrite", 1'b0, mdrWrite);
		checkBit("pcWrite", 1'b0, pcWrite);
		checkBit("pcCond", 1'b0, pcCond);
		checkBit("branchOnEqual", 1'b0, branchOnEqual);
		checkBit("irWrite", 1'b0, irWrite);
		checkBit("aWrite", 1'b0, aWrite);
		checkBit("bWrite", 1'b0, bWrite);
		checkBit("regWrite", 1'b0, regWrite);
		checkBit("aluSrcA", 1'b0, aluSrcA);
		checkBit("aluOutWrite", 1'b0, aluOutWrite);
		checkBit("epcWrite", 1'b0, epcWrite);
		checkPcSource(mipsCtrlPkg::PcAluResult);
		checkSrcB(mipsCtrlPkg::SrcBRegB);
		checkAluOp(mipsCtrlPkg::AluLoadA);
		checkWb(mipsCtrlPkg::DstRt, mipsCtrlPkg::WbAluOut);
		checkAddrSel(mipsCtrlPkg::AddrPc);
	endtask

	// one cycle, outputs sampled at the falling edge before anything is driven
	task automatic step();
		@(negedge clk);
		cycles++;
		if (state != mipsCtrlPkg::IRWrite)
		begin
			nRegWrite += int'(regWrite);
			nMemWrite += int'(memWrite);
			nMdrWrite += int'(mdrWrite);
			nPcWrite += int'(pcWrite);
			nPcCond += int'(pcCond);
			nEpcWrite += int'(epcWrite);
		end
	endtask

	task automatic startInstr(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] sh);
		int tries;
		tries = 0;
		while (state != mipsCtrlPkg::IRWrite && tries < 12)
		begin
			step();
			tries++;
		end
		if (state != mipsCtrlPkg::IRWrite)
			noteFailure("the unit never reached IRWrite to take a new instruction");
		opcode = op; // fields held by the datapath until the next IRWrite
		funct = fn;
		shamt = sh;
		startCycle = cycles;
		nRegWrite = 0;
		nMemWrite = 0;
		nMdrWrite = 0;
		nPcWrite = 0;
		nPcCond = 0;
		nEpcWrite = 0;
	endtask

	// decode, the execute steps, then MemoryRead and WaitMemoryRead before IRWrite
	task automatic finishInstr(input int execSteps, input string name);
		int tries;
		tries = 0;
		step();
		while (state != mipsCtrlPkg::IRWrite && tries < 16)
		begin
			step();
			tries++;
		end
		if (cycles - startCycle != execSteps + 4)
			noteFailure($sformatf("%s took %0d cycles between IRWrite states instead of %0d",
				name, cycles - startCycle, execSteps + 4));
	endtask

	task automatic resetAndFetch();
		repeat (ResetCycles)
		begin
			step();
			checkState(mipsCtrlPkg::Reset);
			checkBit("memWrite", 1'b0, memWrite);
			checkBit("regWrite", 1'b0, regWrite);
			checkBit("pcWrite", 1'b0, pcWrite);
			checkBit("pcCond", 1'b0, pcCond);
			checkBit("epcWrite", 1'b0, epcWrite);
			checkBit("mdrWrite", 1'b0, mdrWrite);
			checkBit("aWrite", 1'b0, aWrite);
			checkBit("bWrite", 1'b0, bWrite);
		end
		reset = 1'b0;
		step();
		checkState(mipsCtrlPkg::MemoryRead);
		checkBit("pcWrite", 1'b0, pcWrite);
		checkBit("irWrite", 1'b1, irWrite);
		checkAddrSel(mipsCtrlPkg::AddrPc);
		checkSrcB(mipsCtrlPkg::SrcBFour);
		step();
		checkState(mipsCtrlPkg::WaitMemoryRead);
		checkBit("pcWrite", 1'b0, pcWrite);
		step();
		checkState(mipsCtrlPkg::IRWrite);
		checkBit("pcWrite", 1'b1, pcWrite); // pc + 4
		checkAddrSel(mipsCtrlPkg::AddrPc);
		step();
		checkState(mipsCtrlPkg::Decode);
		checkBit("pcWrite", 1'b0, pcWrite);
		checkBit("aluOutWrite", 1'b1, aluOutWrite);
		checkSrcB(mipsCtrlPkg::SrcBImmShifted);
		step();
		checkState(mipsCtrlPkg::Nop); // fields start as all zero
		checkBit("pcWrite", 1'b0, pcWrite);
	endtask

	task automatic aluInstr(input mipsCtrlPkg::funct_t fn, input mipsCtrlPkg::ctrlState_t exec,
		input mipsCtrlPkg::aluOp_t op);
		startInstr(mipsCtrlPkg::OpRType, fn, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(exec);
		checkAluOp(op);
		checkBit("regWrite", 1'b0, regWrite);
		step();
		checkState(mipsCtrlPkg::WriteRegAlu);
		checkBit("regWrite", 1'b1, regWrite);
		checkWb(mipsCtrlPkg::DstRd, mipsCtrlPkg::WbAluOut);
		finishInstr(2, fn.name());
		checkCount("regWrite", 1, nRegWrite);
	endtask

	task automatic sltInstr(input logic less);
		startInstr(mipsCtrlPkg::OpRType, mipsCtrlPkg::FnSlt, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::Slt);
		checkAluOp(mipsCtrlPkg::AluSlt);
		menor = less; // settles before SltWrite
		step();
		checkState(mipsCtrlPkg::SltWrite);
		checkBit("regWrite", 1'b1, regWrite);
		checkWb(mipsCtrlPkg::DstRd, less ? mipsCtrlPkg::WbOne : mipsCtrlPkg::WbZero);
		finishInstr(2, "slt");
		checkCount("regWrite", 1, nRegWrite);
	endtask

	task automatic storeWord();
		startInstr(mipsCtrlPkg::OpSw, mipsCtrlPkg::FnSll, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::Sw);
		checkBit("aluOutWrite", 1'b1, aluOutWrite);
		checkSrcB(mipsCtrlPkg::SrcBImm);
		step();
		checkState(mipsCtrlPkg::SwAddr);
		checkBit("memWrite", 1'b1, memWrite);
		checkAddrSel(mipsCtrlPkg::AddrAluOut);
		step();
		checkState(mipsCtrlPkg::SwWait);
		finishInstr(3, "sw");
		checkCount("memWrite", 2, nMemWrite);
		checkCount("regWrite", 0, nRegWrite);
	endtask

	task automatic loadWord();
		startInstr(mipsCtrlPkg::OpLw, mipsCtrlPkg::FnSll, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::Lw);
		checkBit("aluOutWrite", 1'b1, aluOutWrite);
		checkSrcB(mipsCtrlPkg::SrcBImm);
		repeat (2) step();
		checkState(mipsCtrlPkg::LwWait);
		step();
		checkState(mipsCtrlPkg::LwMdr);
		checkBit("mdrWrite", 1'b1, mdrWrite);
		step();
		checkState(mipsCtrlPkg::LwWrite);
		checkBit("regWrite", 1'b1, regWrite);
		checkWb(mipsCtrlPkg::DstRt, mipsCtrlPkg::WbMdr);
		finishInstr(5, "lw");
		checkCount("mdrWrite", 1, nMdrWrite);
		checkCount("regWrite", 1, nRegWrite);
		checkCount("memWrite", 0, nMemWrite);
	endtask

	task automatic branch(input mipsCtrlPkg::opcode_t op, input mipsCtrlPkg::ctrlState_t st,
		input logic eq);
		startInstr(op, mipsCtrlPkg::FnSll, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(st);
		checkBit("pcCond", 1'b1, pcCond);
		checkBit("branchOnEqual", eq, branchOnEqual);
		checkPcSource(mipsCtrlPkg::PcAluOut);
		checkAluOp(mipsCtrlPkg::AluSub);
		finishInstr(1, st.name());
		checkCount("pcCond", 1, nPcCond);
	endtask

	task automatic jump(input logic [5:0] op, input logic [5:0] fn,
		input mipsCtrlPkg::ctrlState_t st, input mipsCtrlPkg::pcSource_t src);
		startInstr(op, fn, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(st);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(src);
		finishInstr(1, st.name());
		checkCount("pcWrite", 1, nPcWrite);
	endtask

	task automatic jalInstr();
		startInstr(mipsCtrlPkg::OpJal, mipsCtrlPkg::FnSll, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::JalWriteRa);
		checkBit("regWrite", 1'b1, regWrite);
		checkBit("pcWrite", 1'b0, pcWrite); // return address goes first
		checkWb(mipsCtrlPkg::DstRa, mipsCtrlPkg::WbPc);
		step();
		checkState(mipsCtrlPkg::Jal);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(mipsCtrlPkg::PcJumpTarget);
		finishInstr(2, "jal");
	endtask

	task automatic luiInstr();
		startInstr(mipsCtrlPkg::OpLui, mipsCtrlPkg::FnSll, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::Lui);
		checkBit("regWrite", 1'b1, regWrite);
		checkWb(mipsCtrlPkg::DstRt, mipsCtrlPkg::WbLuiImm);
		finishInstr(1, "lui");
	endtask

	task automatic addiuInstr();
		startInstr(mipsCtrlPkg::OpAddiu, mipsCtrlPkg::FnSll, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::Addiu);
		checkBit("aluOutWrite", 1'b1, aluOutWrite);
		checkSrcB(mipsCtrlPkg::SrcBImm);
		step();
		checkState(mipsCtrlPkg::WriteRegAluImm);
		checkBit("regWrite", 1'b1, regWrite);
		checkWb(mipsCtrlPkg::DstRt, mipsCtrlPkg::WbAluOut);
		finishInstr(2, "addiu");
		checkCount("regWrite", 1, nRegWrite);
	endtask

	task automatic illegalTrap(input logic [5:0] op, input logic [5:0] fn, input logic [4:0] sh,
		input string name);
		startInstr(op, fn, sh);
		step();
		checkState(mipsCtrlPkg::Decode);
		step();
		checkState(mipsCtrlPkg::ExcSaveEpc);
		checkBit("epcWrite", 1'b1, epcWrite);
		checkAluOp(mipsCtrlPkg::AluSub);
		checkAddrSel(mipsCtrlPkg::AddrExcVector);
		step();
		checkState(mipsCtrlPkg::ExcWait);
		checkAddrSel(mipsCtrlPkg::AddrExcVector);
		step();
		checkState(mipsCtrlPkg::ExcMdr);
		checkBit("mdrWrite", 1'b1, mdrWrite);
		checkAddrSel(mipsCtrlPkg::AddrExcVector);
		step();
		checkState(mipsCtrlPkg::ExcJump);
		checkBit("pcWrite", 1'b1, pcWrite);
		checkPcSource(mipsCtrlPkg::PcExcVector);
		finishInstr(4, name);
		checkCount("epcWrite", 1, nEpcWrite);
		checkCount("pcWrite", 1, nPcWrite);
	endtask

	// the unit halts here, so this runs last
	task automatic breakHalt();
		startInstr(mipsCtrlPkg::OpRType, mipsCtrlPkg::FnBreak, 5'd0);
		step();
		checkState(mipsCtrlPkg::Decode);
		repeat (20)
		begin
			step();
			checkState(mipsCtrlPkg::Break);
			checkHaltWord();
		end
		checkCount("pcWrite", 0, nPcWrite);
	endtask

	initial
	begin
		errors = 0;
		cycles = 0;
		startCycle = 0;
		clk = 1'b0;
		reset = 1'b1;
		menor = 1'b0;
		opcode = '0;
		funct = '0;
		shamt = '0;
		resetAndFetch();
		aluInstr(mipsCtrlPkg::FnAdd, mipsCtrlPkg::Add, mipsCtrlPkg::AluAdd);
		aluInstr(mipsCtrlPkg::FnAnd, mipsCtrlPkg::And, mipsCtrlPkg::AluAnd);
		aluInstr(mipsCtrlPkg::FnSub, mipsCtrlPkg::Sub, mipsCtrlPkg::AluSub);
		aluInstr(mipsCtrlPkg::FnXor, mipsCtrlPkg::Xor, mipsCtrlPkg::AluXor);
		sltInstr(1'b1);
		sltInstr(1'b0);
		storeWord();
		loadWord();
		branch(mipsCtrlPkg::OpBeq, mipsCtrlPkg::Beq, 1'b1);
		branch(mipsCtrlPkg::OpBne, mipsCtrlPkg::Bne, 1'b0);
		jump(mipsCtrlPkg::OpJ, mipsCtrlPkg::FnSll, mipsCtrlPkg::J, mipsCtrlPkg::PcJumpTarget);
		jump(mipsCtrlPkg::OpRType, mipsCtrlPkg::FnJr, mipsCtrlPkg::Jr, mipsCtrlPkg::PcRegA);
		jalInstr();
		luiInstr();
		addiuInstr();
		illegalTrap(6'h3f, mipsCtrlPkg::FnSll, 5'd0, "undefined opcode");
		illegalTrap(mipsCtrlPkg::OpRType, mipsCtrlPkg::FnSll, 5'd3, "sll with shamt");
		breakHalt();
		$display("Errors counted: %0d", errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// ==== testbench/controlUnit_sva.sv ====
`timescale 1ns/1ps

module controlUnitSva
(
	input logic clk,
	input logic reset,
	input logic pcWrite,
	input logic pcCond,
	input logic regWrite,
	input logic memWrite,
	input logic epcWrite,
	input mipsCtrlPkg::ctrlState_t state
);

	pcWriteExclusive: assert property (@(posedge clk) disable iff (reset) !(pcWrite && pcCond))
		else $error("pcWrite and pcCond are high together");

	regMemExclusive: assert property (@(posedge clk) disable iff (reset) !(regWrite && memWrite))
		else $error("regWrite and memWrite are high together");

	// epc saved once per trap
	epcSinglePulse: assert property (@(posedge clk) disable iff (reset) epcWrite |=> !epcWrite)
		else $error("epcWrite stayed high for more than one cycle");

	resetState: assert property (@(posedge clk) reset |-> state == mipsCtrlPkg::Reset)
		else $error("state left Reset while reset is high");

endmodule

bind controlUnit controlUnitSva sva
(
	.clk(clk),
	.reset(reset),
	.pcWrite(pcWrite),
	.pcCond(pcCond),
	.regWrite(regWrite),
	.memWrite(memWrite),
	.epcWrite(epcWrite),
	.state(state)
);
